// File: rtl/CoreTypes.sv
// Core types: data widths, RV32I opcodes and the instruction word views
`default_nettype none

package CoreTypes;

    typedef logic [31:0] DataPath;
    typedef logic [31:0] AddrPath;
    typedef logic [3:0] MemAccessSerial;
    typedef logic [3:0] MemWriteSerial;
    typedef logic [4:0] RegNum;
    typedef logic [7:0] SerialDataPath;

    // Major opcodes of the supported subset
    localparam logic [6:0] OpcodeOp = 7'b0110011;
    localparam logic [6:0] OpcodeOpImm = 7'b0010011;
    localparam logic [6:0] OpcodeLui = 7'b0110111;
    localparam logic [6:0] OpcodeLoad = 7'b0000011;
    localparam logic [6:0] OpcodeStore = 7'b0100011;
    localparam logic [6:0] OpcodeBranch = 7'b1100011;

    localparam logic [2:0] Funct3Add = 3'b000;
    localparam logic [2:0] Funct3Word = 3'b010;
    localparam logic [2:0] Funct3Bne = 3'b001;
    localparam logic [6:0] Funct7Add = 7'b0000000;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            RegNum rs2;
            RegNum rs1;
            logic [2:0] funct3;
            RegNum rd;
            logic [6:0] opcode;
        } rType;
        struct packed {
            logic [11:0] imm;
            RegNum rs1;
            logic [2:0] funct3;
            RegNum rd;
            logic [6:0] opcode;
        } iType;
        struct packed {
            logic [6:0] immHigh;
            RegNum rs2;
            RegNum rs1;
            logic [2:0] funct3;
            logic [4:0] immLow;
            logic [6:0] opcode;
        } sType;
        struct packed {
            logic imm12;
            logic [5:0] imm10to5;
            RegNum rs2;
            RegNum rs1;
            logic [2:0] funct3;
            logic [3:0] imm4to1;
            logic imm11;
            logic [6:0] opcode;
        } bType;
        struct packed {
            logic [19:0] imm;
            RegNum rd;
            logic [6:0] opcode;
        } uType;
    } InstructionWord;

endpackage

`default_nettype wire

// File: rtl/RegisterFile.sv
// Register file: 32 integer registers, two async reads, one clocked write
`default_nettype none

module RegisterFile (
    input  wire logic clk,
    input  wire logic reset,
    input  CoreTypes::RegNum readNum1,
    input  CoreTypes::RegNum readNum2,
    input  wire logic writeEnable,
    input  CoreTypes::RegNum writeNum,
    input  CoreTypes::DataPath writeData,
    output CoreTypes::DataPath readData1,
    output CoreTypes::DataPath readData2
);

    CoreTypes::DataPath regs [0:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeNum != '0) begin
            regs[writeNum] <= writeData;
        end
    end

    // x0 always reads as zero
    assign readData1 = (readNum1 == '0) ? '0 : regs[readNum1];
    assign readData2 = (readNum2 == '0) ? '0 : regs[readNum2];

endmodule

`default_nettype wire

// File: rtl/ExecutionUnit.sv
// Execution unit: decodes the current instruction, computes ALU, address and branch results
`default_nettype none

module ExecutionUnit (
    input  CoreTypes::InstructionWord instruction,
    input  CoreTypes::AddrPath pc,
    input  CoreTypes::DataPath operand1,
    input  CoreTypes::DataPath operand2,
    output CoreTypes::RegNum readNum1,
    output CoreTypes::RegNum readNum2,
    output CoreTypes::DataPath aluResult,
    output CoreTypes::AddrPath memAddr,
    output CoreTypes::DataPath storeData,
    output logic branchTaken,
    output CoreTypes::AddrPath branchTarget,
    output logic isLoad,
    output logic isStore,
    output logic writesReg,
    output CoreTypes::RegNum destReg
);

    CoreTypes::DataPath immI;
    CoreTypes::DataPath immS;
    CoreTypes::DataPath immB;
    CoreTypes::DataPath immU;

    // Register fields share their bit positions across formats
    assign readNum1 = instruction.rType.rs1;
    assign readNum2 = instruction.rType.rs2;
    assign destReg = instruction.rType.rd;

    assign immI = {{20{instruction.iType.imm[11]}}, instruction.iType.imm};
    assign immS = {{20{instruction.sType.immHigh[6]}},
                   instruction.sType.immHigh, instruction.sType.immLow};
    assign immB = {{19{instruction.bType.imm12}}, instruction.bType.imm12,
                   instruction.bType.imm11, instruction.bType.imm10to5,
                   instruction.bType.imm4to1, 1'b0};
    assign immU = {instruction.uType.imm, 12'b0};

    assign storeData = operand2;
    assign branchTarget = pc + immB;

    always_comb begin
        aluResult = '0;
        memAddr = '0;
        branchTaken = 1'b0;
        isLoad = 1'b0;
        isStore = 1'b0;
        writesReg = 1'b0;
        // Unknown encodings fall through as a no-op
        case (instruction.rType.opcode)
            CoreTypes::OpcodeOp: begin
                if (instruction.rType.funct3 == CoreTypes::Funct3Add &&
                    instruction.rType.funct7 == CoreTypes::Funct7Add) begin
                    aluResult = operand1 + operand2;
                    writesReg = 1'b1;
                end
            end
            CoreTypes::OpcodeOpImm: begin
                if (instruction.iType.funct3 == CoreTypes::Funct3Add) begin
                    aluResult = operand1 + immI;
                    writesReg = 1'b1;
                end
            end
            CoreTypes::OpcodeLui: begin
                aluResult = immU;
                writesReg = 1'b1;
            end
            CoreTypes::OpcodeLoad: begin
                if (instruction.iType.funct3 == CoreTypes::Funct3Word) begin
                    memAddr = operand1 + immI;
                    isLoad = 1'b1;
                    writesReg = 1'b1;
                end
            end
            CoreTypes::OpcodeStore: begin
                if (instruction.sType.funct3 == CoreTypes::Funct3Word) begin
                    memAddr = operand1 + immS;
                    isStore = 1'b1;
                end
            end
            CoreTypes::OpcodeBranch: begin
                if (instruction.bType.funct3 == CoreTypes::Funct3Bne) begin
                    branchTaken = operand1 != operand2;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/MemoryAccessController.sv
// Memory access controller: drives the external port, matches serials, routes serial-port stores
`default_nettype none

module MemoryAccessController #(
    parameter CoreTypes::AddrPath SerialPortAddr
) (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic reqRead,
    input  wire logic reqWrite,
    input  CoreTypes::AddrPath reqAddr,
    input  CoreTypes::DataPath reqWriteData,
    input  CoreTypes::MemAccessSerial nextMemReadSerial,
    input  CoreTypes::MemWriteSerial nextMemWriteSerial,
    input  CoreTypes::DataPath memReadData,
    input  wire logic memReadDataReady,
    input  CoreTypes::MemAccessSerial memReadSerial,
    input  wire logic memAccessResponseValid,
    input  CoreTypes::MemWriteSerial memAccessResponseSerial,
    input  wire logic memAccessReadBusy,
    input  wire logic memAccessWriteBusy,
    output logic reqAccepted,
    output logic readDone,
    output CoreTypes::DataPath readData,
    output logic writeDone,
    output CoreTypes::AddrPath memAccessAddr,
    output CoreTypes::DataPath memAccessWriteData,
    output logic memAccessRE,
    output logic memAccessWE,
    output logic serialWE,
    output CoreTypes::SerialDataPath serialWriteData
);

    logic isSerialAddr;
    logic readAccepted;
    logic writeAccepted;
    logic readPending;
    logic writePending;
    CoreTypes::MemAccessSerial readSerial;
    CoreTypes::MemWriteSerial writeSerial;

    assign isSerialAddr = reqAddr == SerialPortAddr;

    // Requests come from controller registers, so they hold steady under busy
    assign memAccessRE = reqRead;
    assign memAccessWE = reqWrite && !isSerialAddr;
    assign memAccessAddr = reqAddr;
    assign memAccessWriteData = reqWriteData;

    assign readAccepted = memAccessRE && !memAccessReadBusy;
    assign writeAccepted = memAccessWE && !memAccessWriteBusy;
    assign reqAccepted = readAccepted || writeAccepted;

    always_ff @(posedge clk) begin
        if (reset) begin
            readPending <= 1'b0;
            writePending <= 1'b0;
        end else begin
            if (readAccepted) begin
                readPending <= 1'b1;
            end else if (readDone) begin
                readPending <= 1'b0;
            end
            if (writeAccepted) begin
                writePending <= 1'b1;
            end else if (writeDone) begin
                writePending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (readAccepted) begin
            readSerial <= nextMemReadSerial;
        end
        if (writeAccepted) begin
            writeSerial <= nextMemWriteSerial;
        end
    end

    // Responses tagged with some other serial are dropped
    assign readDone = readPending && memReadDataReady && memReadSerial == readSerial;
    assign readData = memReadData;

    assign serialWE = reqWrite && isSerialAddr;
    assign serialWriteData = reqWriteData[7:0];

    assign writeDone = serialWE ||
        (writePending && memAccessResponseValid && memAccessResponseSerial == writeSerial);

endmodule

`default_nettype wire

// File: rtl/Controller.sv
// Controller: multi-cycle FSM that holds the PC, sequences fetch, execute and memory, commits
`default_nettype none

module Controller (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic reqAccepted,
    input  wire logic readDone,
    input  CoreTypes::DataPath readData,
    input  wire logic writeDone,
    input  CoreTypes::DataPath aluResult,
    input  CoreTypes::AddrPath memAddr,
    input  CoreTypes::DataPath storeData,
    input  wire logic branchTaken,
    input  CoreTypes::AddrPath branchTarget,
    input  wire logic isLoad,
    input  wire logic isStore,
    input  wire logic writesReg,
    input  CoreTypes::RegNum destReg,
    output logic reqRead,
    output logic reqWrite,
    output CoreTypes::AddrPath reqAddr,
    output CoreTypes::DataPath reqWriteData,
    output CoreTypes::InstructionWord instruction,
    output CoreTypes::AddrPath pc,
    output logic regWriteEnable,
    output CoreTypes::RegNum regWriteNum,
    output CoreTypes::DataPath regWriteData,
    output CoreTypes::AddrPath lastCommittedPC
);

    localparam logic [2:0] StateFetch = 3'd0;
    localparam logic [2:0] StateWaitInst = 3'd1;
    localparam logic [2:0] StateExecute = 3'd2;
    localparam logic [2:0] StateMemReq = 3'd3;
    localparam logic [2:0] StateMemWait = 3'd4;

    logic [2:0] state;
    logic commit;

    assign commit = (state == StateExecute && !isLoad && !isStore) ||
                    (state == StateMemReq && writeDone) ||
                    (state == StateMemWait && (readDone || writeDone));

    // Operands stay put until commit, so the data address needs no copy
    assign reqAddr = (state == StateFetch) ? pc : memAddr;
    assign reqWriteData = storeData;

    assign regWriteEnable = commit && writesReg;
    assign regWriteNum = destReg;
    assign regWriteData = isLoad ? readData : aluResult;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= StateFetch;
            reqRead <= 1'b0;
            reqWrite <= 1'b0;
            pc <= '0;
            lastCommittedPC <= '0;
        end else begin
            case (state)
                StateFetch: begin
                    // Request comes up one cycle late only right after reset
                    if (!reqRead) begin
                        reqRead <= 1'b1;
                    end else if (reqAccepted) begin
                        reqRead <= 1'b0;
                        state <= StateWaitInst;
                    end
                end
                StateWaitInst: begin
                    if (readDone) begin
                        state <= StateExecute;
                    end
                end
                StateExecute: begin
                    if (isLoad) begin
                        reqRead <= 1'b1;
                        state <= StateMemReq;
                    end else if (isStore) begin
                        reqWrite <= 1'b1;
                        state <= StateMemReq;
                    end
                end
                StateMemReq: begin
                    if (reqAccepted) begin
                        reqRead <= 1'b0;
                        reqWrite <= 1'b0;
                        state <= StateMemWait;
                    end
                end
                default: begin
                end
            endcase
            if (commit) begin
                state <= StateFetch;
                reqRead <= 1'b1;
                reqWrite <= 1'b0;
                pc <= branchTaken ? branchTarget : pc + 32'd4;
                lastCommittedPC <= pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == StateWaitInst && readDone) begin
            instruction <= readData;
        end
    end

endmodule

`default_nettype wire

// File: rtl/Core.sv
// Core top level: connects controller, register file, execution unit and memory access
`default_nettype none

module Core #(
    parameter CoreTypes::AddrPath SerialPortAddr = 32'h4000_0000
) (
    input  wire logic clk,
    input  wire logic reset,
    input  CoreTypes::MemAccessSerial nextMemReadSerial,
    input  CoreTypes::MemWriteSerial nextMemWriteSerial,
    input  CoreTypes::DataPath memReadData,
    input  wire logic memReadDataReady,
    input  CoreTypes::MemAccessSerial memReadSerial,
    input  wire logic memAccessResponseValid,
    input  CoreTypes::MemWriteSerial memAccessResponseSerial,
    input  wire logic memAccessReadBusy,
    input  wire logic memAccessWriteBusy,
    output CoreTypes::AddrPath lastCommittedPC,
    output CoreTypes::AddrPath memAccessAddr,
    output CoreTypes::DataPath memAccessWriteData,
    output logic memAccessRE,
    output logic memAccessWE,
    output logic serialWE,
    output CoreTypes::SerialDataPath serialWriteData
);

    // Controller to memory access controller
    logic reqRead;
    logic reqWrite;
    CoreTypes::AddrPath reqAddr;
    CoreTypes::DataPath reqWriteData;
    logic reqAccepted;
    logic readDone;
    CoreTypes::DataPath readData;
    logic writeDone;

    // Controller and execution unit
    CoreTypes::InstructionWord instruction;
    CoreTypes::AddrPath pc;
    CoreTypes::DataPath aluResult;
    CoreTypes::AddrPath memAddr;
    CoreTypes::DataPath storeData;
    logic branchTaken;
    CoreTypes::AddrPath branchTarget;
    logic isLoad;
    logic isStore;
    logic writesReg;
    CoreTypes::RegNum destReg;

    // Register file
    CoreTypes::RegNum readNum1;
    CoreTypes::RegNum readNum2;
    CoreTypes::DataPath operand1;
    CoreTypes::DataPath operand2;
    logic regWriteEnable;
    CoreTypes::RegNum regWriteNum;
    CoreTypes::DataPath regWriteData;

    Controller u_Controller (
        .clk(clk),
        .reset(reset),
        .reqAccepted(reqAccepted),
        .readDone(readDone),
        .readData(readData),
        .writeDone(writeDone),
        .aluResult(aluResult),
        .memAddr(memAddr),
        .storeData(storeData),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget),
        .isLoad(isLoad),
        .isStore(isStore),
        .writesReg(writesReg),
        .destReg(destReg),
        .reqRead(reqRead),
        .reqWrite(reqWrite),
        .reqAddr(reqAddr),
        .reqWriteData(reqWriteData),
        .instruction(instruction),
        .pc(pc),
        .regWriteEnable(regWriteEnable),
        .regWriteNum(regWriteNum),
        .regWriteData(regWriteData),
        .lastCommittedPC(lastCommittedPC)
    );

    RegisterFile u_RegisterFile (
        .clk(clk),
        .reset(reset),
        .readNum1(readNum1),
        .readNum2(readNum2),
        .writeEnable(regWriteEnable),
        .writeNum(regWriteNum),
        .writeData(regWriteData),
        .readData1(operand1),
        .readData2(operand2)
    );

    ExecutionUnit u_ExecutionUnit (
        .instruction(instruction),
        .pc(pc),
        .operand1(operand1),
        .operand2(operand2),
        .readNum1(readNum1),
        .readNum2(readNum2),
        .aluResult(aluResult),
        .memAddr(memAddr),
        .storeData(storeData),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget),
        .isLoad(isLoad),
        .isStore(isStore),
        .writesReg(writesReg),
        .destReg(destReg)
    );

    MemoryAccessController #(
        .SerialPortAddr(SerialPortAddr)
    ) u_MemoryAccessController (
        .clk(clk),
        .reset(reset),
        .reqRead(reqRead),
        .reqWrite(reqWrite),
        .reqAddr(reqAddr),
        .reqWriteData(reqWriteData),
        .nextMemReadSerial(nextMemReadSerial),
        .nextMemWriteSerial(nextMemWriteSerial),
        .memReadData(memReadData),
        .memReadDataReady(memReadDataReady),
        .memReadSerial(memReadSerial),
        .memAccessResponseValid(memAccessResponseValid),
        .memAccessResponseSerial(memAccessResponseSerial),
        .memAccessReadBusy(memAccessReadBusy),
        .memAccessWriteBusy(memAccessWriteBusy),
        .reqAccepted(reqAccepted),
        .readDone(readDone),
        .readData(readData),
        .writeDone(writeDone),
        .memAccessAddr(memAccessAddr),
        .memAccessWriteData(memAccessWriteData),
        .memAccessRE(memAccessRE),
        .memAccessWE(memAccessWE),
        .serialWE(serialWE),
        .serialWriteData(serialWriteData)
    );

endmodule

`default_nettype wire

// File: tb/Core_chk.sv
// Port protocol checker bound into Core: request stability, exclusivity, serial strobe
`default_nettype none

module Core_chk (
    input wire logic clk,
    input wire logic reset,
    input CoreTypes::AddrPath memAccessAddr,
    input CoreTypes::DataPath memAccessWriteData,
    input wire logic memAccessRE,
    input wire logic memAccessWE,
    input wire logic memAccessReadBusy,
    input wire logic memAccessWriteBusy,
    input wire logic serialWE
);

    int failures = 0;

    // Held read request under busy
    readHold: assert property (@(posedge clk) disable iff (reset)
        memAccessRE && memAccessReadBusy |=> memAccessRE && $stable(memAccessAddr))
        else begin
            $error("read request changed while busy");
            failures++;
        end

    writeHold: assert property (@(posedge clk) disable iff (reset)
        memAccessWE && memAccessWriteBusy |=>
            memAccessWE && $stable(memAccessAddr) && $stable(memAccessWriteData))
        else begin
            $error("write request changed while busy");
            failures++;
        end

    noReadWrite: assert property (@(posedge clk) disable iff (reset)
        !(memAccessRE && memAccessWE))
        else begin
            $error("read and write raised together");
            failures++;
        end

    // A serial-port store leaves the memory port idle
    serialOffPort: assert property (@(posedge clk) disable iff (reset)
        !(serialWE && (memAccessWE || memAccessRE)))
        else begin
            $error("serial strobe together with a memory request");
            failures++;
        end

    serialPulse: assert property (@(posedge clk) disable iff (reset)
        serialWE |=> !serialWE)
        else begin
            $error("serial strobe longer than one cycle");
            failures++;
        end

endmodule

`default_nettype wire

// File: tb/TestProgram.svh
// Test program: instruction image, expected serial bytes, memory writes and PC trace
`ifndef TEST_PROGRAM_SVH
`define TEST_PROGRAM_SVH

localparam int ProgramLength = 20;
localparam logic [31:0] ProgramImage [0:ProgramLength-1] = '{
    32'h00500093, // 00 addi x1, x0, 5
    32'h00700113, // 04 addi x2, x0, 7
    32'h002081B3, // 08 add  x3, x1, x2
    32'h40000237, // 0c lui  x4, 0x40000
    32'h00322023, // 10 sw   x3, 0(x4)
    32'h123452B7, // 14 lui  x5, 0x12345
    32'h06728293, // 18 addi x5, x5, 0x67
    32'h00522023, // 1c sw   x5, 0(x4)
    32'h10000313, // 20 addi x6, x0, 0x100
    32'h00532023, // 24 sw   x5, 0(x6)
    32'h00032383, // 28 lw   x7, 0(x6)
    32'h00138393, // 2c addi x7, x7, 1
    32'h00722023, // 30 sw   x7, 0(x4)
    32'h00000413, // 34 addi x8, x0, 0
    32'h00300493, // 38 addi x9, x0, 3
    32'h00140413, // 3c addi x8, x8, 1
    32'h00832223, // 40 sw   x8, 4(x6)
    32'hFE941CE3, // 44 bne  x8, x9, -8
    32'h00822023, // 48 sw   x8, 0(x4)
    32'h00101063  // 4c bne  x0, x1, 0
};

localparam int SerialCount = 4;
localparam logic [7:0] ExpectedSerial [0:SerialCount-1] = '{8'h0C, 8'h67, 8'h68, 8'h03};

localparam int WriteCount = 4;
localparam logic [31:0] ExpectedWriteAddr [0:WriteCount-1] = '{
    32'h100, 32'h104, 32'h104, 32'h104
};
localparam logic [31:0] ExpectedWriteData [0:WriteCount-1] = '{
    32'h12345067, 32'h1, 32'h2, 32'h3
};

// Committed PCs in order; the last entry repeats forever
localparam int TraceLength = 26;
localparam logic [31:0] PcTrace [0:TraceLength-1] = '{
    32'h00, 32'h04, 32'h08, 32'h0c, 32'h10, 32'h14, 32'h18, 32'h1c, 32'h20,
    32'h24, 32'h28, 32'h2c, 32'h30, 32'h34, 32'h38,
    32'h3c, 32'h40, 32'h44, 32'h3c, 32'h40, 32'h44, 32'h3c, 32'h40, 32'h44,
    32'h48, 32'h4c
};

`endif

// File: tb/CoreTb.sv
// Core testbench: memory model with serials and back-pressure, program checks
`default_nettype none

module CoreTb #(
    parameter CoreTypes::AddrPath SerialPortAddr = 32'h4000_0000
);

    `include "TestProgram.svh"

    localparam int MaxLatency = 8;
    localparam int TimeoutCycles = 200 * ProgramLength * MaxLatency;
    localparam int FetchTarget = 30;

    logic clk;
    logic reset;
    CoreTypes::MemAccessSerial nextMemReadSerial;
    CoreTypes::MemWriteSerial nextMemWriteSerial;
    CoreTypes::DataPath memReadData;
    logic memReadDataReady;
    CoreTypes::MemAccessSerial memReadSerial;
    logic memAccessResponseValid;
    CoreTypes::MemWriteSerial memAccessResponseSerial;
    logic memAccessReadBusy;
    logic memAccessWriteBusy;
    CoreTypes::AddrPath lastCommittedPC;
    CoreTypes::AddrPath memAccessAddr;
    CoreTypes::DataPath memAccessWriteData;
    logic memAccessRE;
    logic memAccessWE;
    logic serialWE;
    CoreTypes::SerialDataPath serialWriteData;

    logic [31:0] mem [0:255];
    logic [3:0] readSerialCtr;
    logic [3:0] writeSerialCtr;
    logic readActive;
    logic staleSent;
    logic [3:0] readTag;
    logic [31:0] readWord;
    int readWait;
    logic writeActive;
    logic [3:0] writeTag;
    int writeWait;
    int resetCycles = 0;
    int fetchCount = 0;
    int serialSeen = 0;
    int writesSeen = 0;
    int errors = 0;
    int checks = 0;
    logic programDone = 1'b0;

    Core u_Core (
        .clk(clk),
        .reset(reset),
        .nextMemReadSerial(nextMemReadSerial),
        .nextMemWriteSerial(nextMemWriteSerial),
        .memReadData(memReadData),
        .memReadDataReady(memReadDataReady),
        .memReadSerial(memReadSerial),
        .memAccessResponseValid(memAccessResponseValid),
        .memAccessResponseSerial(memAccessResponseSerial),
        .memAccessReadBusy(memAccessReadBusy),
        .memAccessWriteBusy(memAccessWriteBusy),
        .lastCommittedPC(lastCommittedPC),
        .memAccessAddr(memAccessAddr),
        .memAccessWriteData(memAccessWriteData),
        .memAccessRE(memAccessRE),
        .memAccessWE(memAccessWE),
        .serialWE(serialWE),
        .serialWriteData(serialWriteData)
    );

    bind Core Core_chk u_Core_chk (
        .clk(clk),
        .reset(reset),
        .memAccessAddr(memAccessAddr),
        .memAccessWriteData(memAccessWriteData),
        .memAccessRE(memAccessRE),
        .memAccessWE(memAccessWE),
        .memAccessReadBusy(memAccessReadBusy),
        .memAccessWriteBusy(memAccessWriteBusy),
        .serialWE(serialWE)
    );

    function automatic logic [31:0] expectedPc(input int n);
        return (n < TraceLength) ? PcTrace[n] : PcTrace[TraceLength-1];
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        assert (expected === actual) else begin
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'hC0DE0000 | (i * 4);
        end
        for (int i = 0; i < ProgramLength; i++) begin
            mem[i] = ProgramImage[i];
        end
    end

    // Observe the DUT at the rising edge
    always @(posedge clk) begin
        if (reset) begin
            if (resetCycles > 0) begin
                checkValue("memAccessRE/WE/serialWE", 32'd0,
                           {29'd0, memAccessRE, memAccessWE, serialWE});
            end
            resetCycles++;
            readActive = 1'b0;
            writeActive = 1'b0;
            readSerialCtr = 4'd0;
            writeSerialCtr = 4'd0;
        end else begin
            if (memAccessRE && !memAccessReadBusy) begin
                readActive = 1'b1;
                staleSent = 1'b0;
                readTag = readSerialCtr;
                readWord = mem[memAccessAddr[9:2]];
                readWait = 1 + int'($urandom % 4);
                readSerialCtr = readSerialCtr + 4'd1;
                // Instruction fetches live below the data area
                if (memAccessAddr < 32'h100) begin
                    checkValue("memAccessAddr", expectedPc(fetchCount), memAccessAddr);
                    if (fetchCount > 0) begin
                        checkValue("lastCommittedPC", expectedPc(fetchCount - 1),
                                   lastCommittedPC);
                    end
                    fetchCount++;
                    if (fetchCount == FetchTarget) begin
                        programDone = 1'b1;
                    end
                end
            end
            if (memAccessWE && !memAccessWriteBusy) begin
                checks++;
                assert (writesSeen < WriteCount && memAccessAddr != SerialPortAddr) else begin
                    $display("Unexpected memory write to address %h", memAccessAddr);
                    errors++;
                end
                if (writesSeen < WriteCount) begin
                    checkValue("memAccessAddr", ExpectedWriteAddr[writesSeen], memAccessAddr);
                    checkValue("memAccessWriteData", ExpectedWriteData[writesSeen],
                               memAccessWriteData);
                end
                mem[memAccessAddr[9:2]] = memAccessWriteData;
                writesSeen++;
                writeActive = 1'b1;
                writeTag = writeSerialCtr;
                writeWait = 1 + int'($urandom % 3);
                writeSerialCtr = writeSerialCtr + 4'd1;
            end
            if (serialWE) begin
                checks++;
                assert (serialSeen < SerialCount) else begin
                    $display("More serial bytes than the program sends");
                    errors++;
                end
                if (serialSeen < SerialCount) begin
                    checkValue("serialWriteData", {24'd0, ExpectedSerial[serialSeen]},
                               {24'd0, serialWriteData});
                end
                serialSeen++;
            end
        end
    end

    // Memory responses and back-pressure change on the falling edge
    always @(negedge clk) begin
        memReadDataReady = 1'b0;
        memAccessResponseValid = 1'b0;
        memAccessReadBusy = ($urandom % 4) == 0;
        memAccessWriteBusy = ($urandom % 4) == 0;
        nextMemReadSerial = readSerialCtr;
        nextMemWriteSerial = writeSerialCtr;
        if (readActive) begin
            readWait--;
            if (readWait == 0) begin
                memReadDataReady = 1'b1;
                memReadSerial = readTag;
                memReadData = readWord;
                readActive = 1'b0;
            end else if (!staleSent && ($urandom % 2) == 1) begin
                memReadDataReady = 1'b1;
                memReadSerial = readTag + 4'd7;
                memReadData = 32'hDEADBEEF;
                staleSent = 1'b1;
            end
        end
        if (writeActive) begin
            writeWait--;
            if (writeWait == 0) begin
                memAccessResponseValid = 1'b1;
                memAccessResponseSerial = writeTag;
                writeActive = 1'b0;
            end
        end
    end

    initial begin
        repeat (TimeoutCycles) @(posedge clk);
        $display("Timeout: the program did not reach its final loop in time");
        $display("checks=%0d errors=%0d assertionFailures=%0d fetches=%0d",
                 checks, errors, u_Core.u_Core_chk.failures, fetchCount);
        $display("sim failed");
        $finish;
    end

    initial begin
        int chkFailures;
        void'($urandom(32'h95ca5443));
        reset = 1'b1;
        nextMemReadSerial = '0;
        nextMemWriteSerial = '0;
        memReadData = '0;
        memReadDataReady = 1'b0;
        memReadSerial = '0;
        memAccessResponseValid = 1'b0;
        memAccessResponseSerial = '0;
        memAccessReadBusy = 1'b0;
        memAccessWriteBusy = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        wait (programDone);
        @(negedge clk);
        checks++;
        assert (serialSeen == SerialCount && writesSeen == WriteCount) else begin
            $display("Wrong number of serial bytes or memory writes");
            errors++;
        end
        chkFailures = u_Core.u_Core_chk.failures;
        $display("checks=%0d errors=%0d assertionFailures=%0d fetches=%0d",
                 checks, errors, chkFailures, fetchCount);
        if (errors == 0 && chkFailures == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+tb
rtl/CoreTypes.sv
rtl/RegisterFile.sv
rtl/ExecutionUnit.sv
rtl/MemoryAccessController.sv
rtl/Controller.sv
rtl/Core.sv
tb/Core_chk.sv
tb/CoreTb.sv

// File: run.sh
#!/bin/sh
# Build and run the Core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f vlog.f --top-module CoreTb -o CoreTbSim \
    && ./obj_dir/CoreTbSim | tee /dev/stderr | grep -q "sim passed" \
    && echo "run.sh: PASS" \
    || { echo "run.sh: FAIL"; exit 1; }
